/* core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;   // rv32e, upper index bit dropped
    typedef logic [11:0] csr_addr_t;

    localparam word_t RESET_PC      = 32'h8000_0000;
    localparam word_t CAUSE_ECALL_M = 32'd11;

    // ==================================================
    // opcodes
    // ==================================================
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // ==================================================
    // control word layout
    // ==================================================
    localparam int CTRL_REG_WE    = 0;
    localparam int CTRL_ALU_OP    = 1;    // 4 bits
    localparam int CTRL_SRC_IMM   = 5;
    localparam int CTRL_SRC_PC    = 6;
    localparam int CTRL_IS_LOAD   = 7;
    localparam int CTRL_IS_STORE  = 8;
    localparam int CTRL_MEM_SIZE  = 9;    // 2 bits
    localparam int CTRL_MEM_UNS   = 11;
    localparam int CTRL_IS_BRANCH = 12;
    localparam int CTRL_IS_JAL    = 13;
    localparam int CTRL_IS_JALR   = 14;
    localparam int CTRL_IS_CSR    = 15;
    localparam int CTRL_CSR_SET   = 16;
    localparam int CTRL_IS_ECALL  = 17;
    localparam int CTRL_IS_MRET   = 18;
    localparam int CTRL_IS_EBREAK = 19;
    localparam int CTRL_W         = 20;

    typedef logic [CTRL_W-1:0] ctrl_t;

    // {funct7[5], funct3} for register ops
    localparam logic [3:0] ALU_ADD    = 4'b0000;
    localparam logic [3:0] ALU_SLL    = 4'b0001;
    localparam logic [3:0] ALU_SLT    = 4'b0010;
    localparam logic [3:0] ALU_SLTU   = 4'b0011;
    localparam logic [3:0] ALU_XOR    = 4'b0100;
    localparam logic [3:0] ALU_SRL    = 4'b0101;
    localparam logic [3:0] ALU_OR     = 4'b0110;
    localparam logic [3:0] ALU_AND    = 4'b0111;
    localparam logic [3:0] ALU_SUB    = 4'b1000;
    localparam logic [3:0] ALU_SRA    = 4'b1101;
    localparam logic [3:0] ALU_PASS_B = 4'b1111;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALT
    } core_state_t;

endpackage

/* fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit
    import core_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  fetch_start,
    input  logic  mem_done,
    input  word_t mem_rdata,
    output word_t inst,
    output logic  inst_valid
);

    logic pending;   // fetch issued, word not back yet

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= pending & mem_done;
            if (fetch_start)
                pending <= 1'b1;
            else if (mem_done)
                pending <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (pending && mem_done)
            inst <= mem_rdata;
    end

    a_no_overlap : assert property (@(posedge clock) disable iff (!rst_n)
        fetch_start |-> !pending);

endmodule

/* decoder.sv */
`timescale 1ns/10ps

module decoder
    import core_pkg::*;
(
    input  word_t     inst,
    output reg_idx_t  rs1,
    output reg_idx_t  rs2,
    output reg_idx_t  rd,
    output word_t     imm,
    output csr_addr_t csr_addr,
    output ctrl_t     ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7b5;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign f7b5     = inst[30];
    assign rs1      = inst[18:15];
    assign rs2      = inst[23:20];
    assign rd       = inst[10:7];
    assign csr_addr = inst[31:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl = '0;   // unknown opcode, no-op
        imm  = imm_i;
        case (opcode)
            OP_LUI: begin
                ctrl[CTRL_REG_WE]       = 1'b1;
                ctrl[CTRL_ALU_OP +: 4]  = ALU_PASS_B;
                ctrl[CTRL_SRC_IMM]      = 1'b1;
                imm                     = imm_u;
            end
            OP_AUIPC: begin
                ctrl[CTRL_REG_WE]  = 1'b1;
                ctrl[CTRL_SRC_IMM] = 1'b1;
                ctrl[CTRL_SRC_PC]  = 1'b1;
                imm                = imm_u;
            end
            OP_JAL: begin
                ctrl[CTRL_REG_WE] = 1'b1;
                ctrl[CTRL_IS_JAL] = 1'b1;
                imm               = imm_j;
            end
            OP_JALR: begin
                ctrl[CTRL_REG_WE]  = 1'b1;
                ctrl[CTRL_IS_JALR] = 1'b1;
            end
            OP_BRANCH: begin
                ctrl[CTRL_IS_BRANCH]   = 1'b1;
                ctrl[CTRL_ALU_OP +: 4] = {1'b0, funct3};   // compare kind
                imm                    = imm_b;
            end
            OP_LOAD: begin
                ctrl[CTRL_REG_WE]        = 1'b1;
                ctrl[CTRL_IS_LOAD]       = 1'b1;
                ctrl[CTRL_SRC_IMM]       = 1'b1;
                ctrl[CTRL_MEM_SIZE +: 2] = funct3[1:0];
                ctrl[CTRL_MEM_UNS]       = funct3[2];
            end
            OP_STORE: begin
                ctrl[CTRL_IS_STORE]      = 1'b1;
                ctrl[CTRL_SRC_IMM]       = 1'b1;
                ctrl[CTRL_MEM_SIZE +: 2] = funct3[1:0];
                imm                      = imm_s;
            end
            OP_IMM: begin
                ctrl[CTRL_REG_WE]      = 1'b1;
                ctrl[CTRL_SRC_IMM]     = 1'b1;
                ctrl[CTRL_ALU_OP +: 4] = {f7b5 & (funct3 == 3'b101), funct3};   // srai only
            end
            OP_REG: begin
                ctrl[CTRL_REG_WE]      = 1'b1;
                ctrl[CTRL_ALU_OP +: 4] = {f7b5, funct3};
            end
            OP_SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        ctrl[CTRL_IS_ECALL]  = (inst[31:20] == 12'h000);
                        ctrl[CTRL_IS_EBREAK] = (inst[31:20] == 12'h001);
                        ctrl[CTRL_IS_MRET]   = (inst[31:20] == 12'h302);
                    end
                    3'b001: begin   // csrrw
                        ctrl[CTRL_REG_WE] = 1'b1;
                        ctrl[CTRL_IS_CSR] = 1'b1;
                    end
                    3'b010: begin   // csrrs
                        ctrl[CTRL_REG_WE]  = 1'b1;
                        ctrl[CTRL_IS_CSR]  = 1'b1;
                        ctrl[CTRL_CSR_SET] = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* reg_file.sv */
`timescale 1ns/10ps

module reg_file
    import core_pkg::*;
(
    input  logic     clock,
    input  logic     we,
    input  reg_idx_t waddr,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [16];

    always_ff @(posedge clock) begin
        if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    // x0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* csr_file.sv */
`timescale 1ns/10ps

module csr_file
    import core_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      csr_we,
    input  logic      csr_set,
    input  csr_addr_t addr,
    input  word_t     wdata,
    output word_t     rdata,
    input  logic      trap,
    input  word_t     trap_pc,
    output word_t     mtvec,
    output word_t     mepc
);

    word_t mstatus;
    word_t mcause;
    word_t new_val;

    always_comb begin
        case (addr)
            CSR_MSTATUS: rdata = mstatus;
            CSR_MTVEC:   rdata = mtvec;
            CSR_MEPC:    rdata = mepc;
            CSR_MCAUSE:  rdata = mcause;
            default:     rdata = '0;
        endcase
    end

    assign new_val = csr_set ? (rdata | wdata) : wdata;   // csrrs : csrrw

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (trap) begin
            mepc   <= trap_pc;
            mcause <= CAUSE_ECALL_M;
        end else if (csr_we) begin
            case (addr)
                CSR_MSTATUS: mstatus <= new_val;
                CSR_MTVEC:   mtvec   <= new_val;
                CSR_MEPC:    mepc    <= new_val;
                CSR_MCAUSE:  mcause  <= new_val;
                default: ;
            endcase
        end
    end

endmodule

/* alu_unit.sv */
`timescale 1ns/10ps

module alu_unit
    import core_pkg::*;
(
    input  ctrl_t ctrl,
    input  word_t rs1_data,
    input  word_t rs2_data,
    input  word_t imm,
    input  word_t pc,
    output word_t result,
    output logic  take_branch
);

    word_t      op_a;
    word_t      op_b;
    word_t      alu_out;
    logic [3:0] alu_op;
    logic       cond;

    assign alu_op = ctrl[CTRL_ALU_OP +: 4];
    assign op_a   = ctrl[CTRL_SRC_PC] ? pc : rs1_data;
    assign op_b   = ctrl[CTRL_SRC_IMM] ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << op_b[4:0];
            ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> op_b[4:0];
            ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            default:  alu_out = op_b;   // pass_b
        endcase
    end

    // link address for jumps
    assign result = (ctrl[CTRL_IS_JAL] | ctrl[CTRL_IS_JALR]) ? pc + 32'd4 : alu_out;

    // funct3 rides in the low alu_op bits
    always_comb begin
        case (alu_op[2:0])
            3'b000:  cond = (op_a == op_b);
            3'b001:  cond = (op_a != op_b);
            3'b100:  cond = $signed(op_a) < $signed(op_b);
            3'b101:  cond = $signed(op_a) >= $signed(op_b);
            3'b110:  cond = op_a < op_b;
            3'b111:  cond = op_a >= op_b;
            default: cond = 1'b0;
        endcase
    end

    assign take_branch = ctrl[CTRL_IS_BRANCH] & cond;

endmodule

/* pc_unit.sv */
`timescale 1ns/10ps

module pc_unit
    import core_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  commit,
    input  ctrl_t ctrl,
    input  logic  take_branch,
    input  word_t imm,
    input  word_t rs1_data,
    input  word_t mtvec,
    input  word_t mepc,
    output word_t pc,
    output logic  next_ready
);

    word_t next_pc;
    word_t jalr_target;

    assign jalr_target = (rs1_data + imm) & ~32'd1;

    always_comb begin
        if (ctrl[CTRL_IS_ECALL])
            next_pc = mtvec;
        else if (ctrl[CTRL_IS_MRET])
            next_pc = mepc;
        else if (ctrl[CTRL_IS_JALR])
            next_pc = jalr_target;
        else if (ctrl[CTRL_IS_JAL] || take_branch)
            next_pc = pc + imm;
        else if (ctrl[CTRL_IS_EBREAK])
            next_pc = pc;   // park on ebreak
        else
            next_pc = pc + 32'd4;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc         <= RESET_PC;
            next_ready <= 1'b0;
        end else begin
            next_ready <= commit;   // new pc visible next cycle
            if (commit)
                pc <= next_pc;
        end
    end

endmodule

/* mem_access.sv */
`timescale 1ns/10ps

module mem_access
    import core_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       inst_valid,
    input  logic       next_ready,
    input  ctrl_t      ctrl,
    input  word_t      addr,
    input  word_t      store_data,
    output logic       mem_req,
    output logic       mem_we,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic [3:0] mem_wstrb,
    input  logic       mem_done,
    input  word_t      mem_rdata,
    output word_t      load_data,
    output logic       fetch_start,
    output logic       commit,
    output logic       trap,
    output logic       halt
);

    core_state_t state;
    logic        boot;       // first fetch after reset
    logic [1:0]  byte_off;
    logic [1:0]  mem_size;
    logic        is_mem;
    logic        fetch_go;
    logic        data_go;
    word_t       rshift;
    word_t       aligned;

    assign mem_size = ctrl[CTRL_MEM_SIZE +: 2];
    assign is_mem   = ctrl[CTRL_IS_LOAD] | ctrl[CTRL_IS_STORE];
    assign fetch_go = (state == S_WB) && (next_ready || boot);
    assign data_go  = (state == S_EXEC) && inst_valid && is_mem;
    assign trap     = commit & ctrl[CTRL_IS_ECALL];

    // ==================================================
    // sequencer
    // ==================================================
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state       <= S_WB;
            boot        <= 1'b1;
            mem_req     <= 1'b0;
            mem_we      <= 1'b0;
            fetch_start <= 1'b0;
            commit      <= 1'b0;
            halt        <= 1'b0;
        end else begin
            mem_req     <= fetch_go | data_go;
            fetch_start <= fetch_go;
            commit      <= 1'b0;
            case (state)
                S_WB: if (fetch_go) begin
                    boot   <= 1'b0;
                    mem_we <= 1'b0;
                    state  <= S_FETCH;
                end
                S_FETCH: if (mem_done) state <= S_EXEC;   // inst_valid lands with it
                S_EXEC: if (inst_valid) begin
                    if (data_go) begin
                        mem_we <= ctrl[CTRL_IS_STORE];
                        state  <= S_MEM;
                    end else begin
                        commit <= 1'b1;
                        halt   <= ctrl[CTRL_IS_EBREAK];
                        state  <= ctrl[CTRL_IS_EBREAK] ? S_HALT : S_WB;
                    end
                end
                S_MEM: if (mem_done) begin
                    commit <= 1'b1;
                    state  <= S_WB;
                end
                default: ;   // halted
            endcase
        end
    end

    // ==================================================
    // request payload and load alignment
    // ==================================================
    assign rshift = mem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (mem_size)
            2'b00:   aligned = ctrl[CTRL_MEM_UNS] ? {24'b0, rshift[7:0]}
                                                  : {{24{rshift[7]}}, rshift[7:0]};
            2'b01:   aligned = ctrl[CTRL_MEM_UNS] ? {16'b0, rshift[15:0]}
                                                  : {{16{rshift[15]}}, rshift[15:0]};
            default: aligned = rshift;
        endcase
    end

    always_ff @(posedge clock) begin
        if (fetch_go) begin
            mem_addr  <= addr;
            mem_wdata <= '0;
            mem_wstrb <= 4'b1111;
            byte_off  <= 2'b00;
        end else if (data_go) begin
            mem_addr  <= {addr[31:2], 2'b00};   // word address, lanes by strobe
            mem_wdata <= store_data << {addr[1:0], 3'b000};
            byte_off  <= addr[1:0];
            case (mem_size)
                2'b00:   mem_wstrb <= 4'b0001 << addr[1:0];
                2'b01:   mem_wstrb <= 4'b0011 << addr[1:0];
                default: mem_wstrb <= 4'b1111;
            endcase
        end
        if (state == S_MEM && mem_done)
            load_data <= aligned;
    end

    a_quiet_halt : assert property (@(posedge clock) disable iff (!rst_n)
        state == S_HALT |-> !mem_req);

endmodule

/* rv_core.sv */
`timescale 1ns/10ps

module rv_core
    import core_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    output logic       mem_req,
    output logic       mem_we,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic [3:0] mem_wstrb,
    input  logic       mem_done,
    input  word_t      mem_rdata,
    output word_t      pc,
    output logic       halt
);

    word_t     inst;
    logic      inst_valid;
    logic      fetch_start;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     imm;
    csr_addr_t csr_addr;
    ctrl_t     ctrl;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     wb_data;
    word_t     csr_rdata;
    word_t     mtvec;
    word_t     mepc;
    word_t     alu_result;
    logic      take_branch;
    logic      next_ready;
    logic      commit;
    logic      trap;
    word_t     load_data;
    word_t     req_addr;

    // ==================================================
    // write-back and request address
    // ==================================================
    assign wb_data  = ctrl[CTRL_IS_LOAD] ? load_data :
                      ctrl[CTRL_IS_CSR]  ? csr_rdata : alu_result;
    assign req_addr = inst_valid ? alu_result : pc;   // exec cycle issues data

    fetch_unit u_fetch (
        .clock       (clock),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata),
        .inst        (inst),
        .inst_valid  (inst_valid)
    );

    decoder u_dec (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .csr_addr (csr_addr),
        .ctrl     (ctrl)
    );

    reg_file u_regs (
        .clock  (clock),
        .we     (commit & ctrl[CTRL_REG_WE]),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    csr_file u_csr (
        .clock   (clock),
        .rst_n   (rst_n),
        .csr_we  (commit & ctrl[CTRL_IS_CSR]),
        .csr_set (ctrl[CTRL_CSR_SET]),
        .addr    (csr_addr),
        .wdata   (rs1_data),
        .rdata   (csr_rdata),
        .trap    (trap),
        .trap_pc (pc),
        .mtvec   (mtvec),
        .mepc    (mepc)
    );

    alu_unit u_alu (
        .ctrl        (ctrl),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .pc          (pc),
        .result      (alu_result),
        .take_branch (take_branch)
    );

    pc_unit u_pc (
        .clock       (clock),
        .rst_n       (rst_n),
        .commit      (commit),
        .ctrl        (ctrl),
        .take_branch (take_branch),
        .imm         (imm),
        .rs1_data    (rs1_data),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .pc          (pc),
        .next_ready  (next_ready)
    );

    mem_access u_mem (
        .clock       (clock),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .next_ready  (next_ready),
        .ctrl        (ctrl),
        .addr        (req_addr),
        .store_data  (rs2_data),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata),
        .load_data   (load_data),
        .fetch_start (fetch_start),
        .commit      (commit),
        .trap        (trap),
        .halt        (halt)
    );

endmodule

/* tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core
    import core_pkg::*;
();

    logic       clock = 1'b0;
    logic       rst_n;
    logic       mem_req;
    logic       mem_we;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic [3:0] mem_wstrb;
    logic       mem_done;
    word_t      mem_rdata;
    word_t      pc;
    logic       halt;

    word_t      testdata [0:255];
    word_t      mem [0:4095];        // 16 KB at RESET_PC
    int         prog_words;
    int         store_count;
    int         store_base;           // first triple in testdata
    int         store_idx;
    int         cycles;
    int         cycle_limit;
    logic [31:0] rng = 32'ha20a_49c0;

    // model request latch
    logic       busy;
    int         wait_cnt;
    logic       first_req;
    logic       req_we;
    word_t      req_addr;
    word_t      req_wdata;
    logic [3:0] req_strb;

    rv_core DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .halt      (halt)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t lane_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    task automatic expect_equal(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    // ==================================================
    // memory model
    // ==================================================
    always @(negedge clock) begin
        mem_done = 1'b0;
        if (rst_n && mem_req) begin
            if (busy)
                stop_run("memory request issued before the previous one was done");
            if (halt)
                stop_run("memory request issued after halt");
            if (first_req) begin
                expect_equal("reset fetch addr", RESET_PC, mem_addr);
                expect_equal("reset fetch we", 32'd0, {31'd0, mem_we});
                expect_equal("reset fetch strobe", 32'hf, {28'd0, mem_wstrb});
                first_req = 1'b0;
            end
            if (mem_addr[31:14] != RESET_PC[31:14])
                stop_run("memory request outside the modeled address range");
            busy      = 1'b1;
            rng       = next_random(rng);
            wait_cnt  = 1 + rng % 4;   // 1 to 4 cycles of latency
            req_we    = mem_we;
            req_addr  = mem_addr;
            req_wdata = mem_wdata;
            req_strb  = mem_wstrb;
        end
        if (busy) begin
            if (wait_cnt == 0) begin
                if (req_we) begin
                    if (store_idx >= store_count)
                        stop_run("more stores than expected");
                    expect_equal("store addr", testdata[store_base + 3*store_idx], req_addr);
                    expect_equal("store strobe", testdata[store_base + 3*store_idx + 2],
                                 {28'd0, req_strb});
                    expect_equal("store data",
                                 testdata[store_base + 3*store_idx + 1] & lane_mask(req_strb),
                                 req_wdata & lane_mask(req_strb));
                    store_idx = store_idx + 1;
                    mem[req_addr[13:2]] = (mem[req_addr[13:2]] & ~lane_mask(req_strb))
                                        | (req_wdata & lane_mask(req_strb));
                end
                mem_rdata = mem[req_addr[13:2]];
                mem_done  = 1'b1;
                busy      = 1'b0;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    // run limit
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
            stop_run("timeout, core did not halt in time");
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int i;
        rst_n       = 1'b0;
        mem_done    = 1'b0;
        mem_rdata   = '0;
        busy        = 1'b0;
        wait_cnt    = 0;
        first_req   = 1'b1;
        store_idx   = 0;
        cycles      = 0;
        $readmemh("rv_core_testdata.hex", testdata);
        prog_words  = testdata[0];
        store_count = testdata[1];
        store_base  = 2 + prog_words;
        cycle_limit = 64 * prog_words;
        for (i = 0; i < 4096; i++)
            mem[i] = (RESET_PC | (i << 2)) ^ 32'h5a3c_c3a5;
        for (i = 0; i < prog_words; i++)
            mem[i] = testdata[2 + i];

        repeat (8) begin
            @(negedge clock);
            expect_equal("reset mem_req", 32'd0, {31'd0, mem_req});
            expect_equal("reset halt", 32'd0, {31'd0, halt});
            expect_equal("reset pc", RESET_PC, pc);
        end
        rst_n = 1'b1;

        while (!halt)
            @(negedge clock);
        expect_equal("halt pc", testdata[store_base + 3*store_count], pc);
        repeat (10) @(negedge clock);   // model flags any late request
        expect_equal("halt pc held", testdata[store_base + 3*store_count], pc);
        expect_equal("store count", store_count, store_idx);
        $display("TEST OK");
        $finish;
    end

endmodule

/* rv_core_testdata.hex */
// header: program word count, store record count
// then program words, then store triples (addr data strobe), then halt pc
00000027 0000000d
800010B7 // 00 lui   x1, 0x80001
FFB00113 // 04 addi  x2, x0, -5
00C00193 // 08 addi  x3, x0, 12
00310233 // 0c add   x4, x2, x3
0040A023 // 10 sw    x4, 0(x1)
40115293 // 14 srai  x5, x2, 1
0050A223 // 18 sw    x5, 4(x1)
00000317 // 1c auipc x6, 0
0060A423 // 20 sw    x6, 8(x1)
002086A3 // 24 sb    x2, 13(x1)
00D08383 // 28 lb    x7, 13(x1)
0070A823 // 2c sw    x7, 16(x1)
00D0C383 // 30 lbu   x7, 13(x1)
0070AA23 // 34 sw    x7, 20(x1)
00209D23 // 38 sh    x2, 26(x1)
01A0D383 // 3c lhu   x7, 26(x1)
0070AE23 // 40 sw    x7, 28(x1)
00310463 // 44 beq   x2, x3, +8   not taken
0230A023 // 48 sw    x3, 32(x1)
00314463 // 4c blt   x2, x3, +8   taken
0200A023 // 50 sw    x0, 32(x1)   skipped
0080046F // 54 jal   x8, +8
0200A023 // 58 sw    x0, 32(x1)   skipped
00C404E7 // 5c jalr  x9, 12(x8)
0200A023 // 60 sw    x0, 32(x1)   skipped
0290A223 // 64 sw    x9, 36(x1)
00000517 // 68 auipc x10, 0
01850513 // 6c addi  x10, x10, 24
30551073 // 70 csrrw x0, mtvec, x10
00000073 // 74 ecall
0230A823 // 78 sw    x3, 48(x1)
00100073 // 7c ebreak
341025F3 // 80 csrrs x11, mepc, x0
02B0A423 // 84 sw    x11, 40(x1)
34202673 // 88 csrrs x12, mcause, x0
02C0A623 // 8c sw    x12, 44(x1)
00458593 // 90 addi  x11, x11, 4
34159073 // 94 csrrw x0, mepc, x11
30200073 // 98 mret
80001000 00000007 0000000f
80001004 fffffffd 0000000f
80001008 8000001c 0000000f
8000100c 0000fb00 00000002
80001010 fffffffb 0000000f
80001014 000000fb 0000000f
80001018 fffb0000 0000000c
8000101c 0000fffb 0000000f
80001020 0000000c 0000000f
80001024 80000060 0000000f
80001028 80000074 0000000f
8000102c 0000000b 0000000f
80001030 0000000c 0000000f
8000007c

/* src.f */
core_pkg.sv
fetch_unit.sv
decoder.sv
reg_file.sv
csr_file.sv
alu_unit.sv
pc_unit.sv
mem_access.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_rv_core

out=$(./obj_dir/Vtb_rv_core 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST OK"
